// File: verilog/board_pkg.sv
package board_pkg;

    // Bus types
    typedef logic [15:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  irq_vec_t;

    // Interrupt vector codes
    localparam irq_vec_t IRQ_NONE  = 4'd0;
    localparam irq_vec_t IRQ_KEY   = 4'd1;
    localparam irq_vec_t IRQ_TIMER = 4'd2;

    // Address map with RAM spanning 4 * MEM_WORDS bytes from RAM_BASE
    localparam addr_t RAM_BASE   = 16'h0000;
    localparam addr_t UART_ADDR  = 16'h2000;
    localparam addr_t KEY_ADDR   = 16'h2004;
    localparam addr_t TIMER_ADDR = 16'h2008;

    // Top level defaults
    localparam int MEM_WORDS_DEF = 2048;
    localparam int TICK_DIV_DEF  = 50_000_000;
    localparam int KEY_DEPTH_DEF = 8;

endpackage

// File: verilog/kbd_pkg.sv
package kbd_pkg;

    typedef logic [7:0] scan_code_t;

    // One keyboard event as it sits in the queue
    typedef struct packed {
        logic       released;
        scan_code_t code;
    } key_event_t;

    // Receiver FSM states
    typedef enum logic [1:0] {
        IDLE,
        DATA,
        PARITY,
        STOP
    } ps2_state_t;

    // Prefix sent before the code of a released key
    localparam scan_code_t BREAK_CODE = 8'hF0;

endpackage

// File: verilog/ps2_receiver.sv
`timescale 1ns/1ns

module ps2_receiver import kbd_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output key_event_t key_event,
    output logic       key_valid,
    output logic       key_make
);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic       dat_bit;

    ps2_state_t state;
    logic [2:0] bit_cnt;
    scan_code_t shift_reg;
    logic       parity_ok;
    logic       break_seen;

    // Both PS/2 lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];
    assign dat_bit  = dat_sync[1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            shift_reg  <= '0;
            parity_ok  <= 1'b0;
            break_seen <= 1'b0;
            key_event  <= '0;
            key_valid  <= 1'b0;
            key_make   <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            key_make  <= 1'b0;
            if (clk_fall) begin
                case (state)
                    IDLE: begin
                        // Wait for a low start bit
                        if (!dat_bit) begin
                            state   <= DATA;
                            bit_cnt <= '0;
                        end
                    end
                    DATA: begin
                        // LSB arrives first
                        shift_reg <= {dat_bit, shift_reg[7:1]};
                        bit_cnt   <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: begin
                        // Odd parity over data plus parity bit
                        parity_ok <= ^{dat_bit, shift_reg};
                        state     <= STOP;
                    end
                    STOP: begin
                        state <= IDLE;
                        if (dat_bit && parity_ok) begin
                            if (shift_reg == BREAK_CODE) begin
                                break_seen <= 1'b1;
                            end else begin
                                key_event.released <= break_seen;
                                key_event.code     <= shift_reg;
                                key_valid          <= 1'b1;
                                key_make           <= !break_seen;
                                break_seen         <= 1'b0;
                            end
                        end else begin
                            // Bad frame also forgets a pending break
                            break_seen <= 1'b0;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // A whole frame lies between two events
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) key_valid |=> !key_valid)
        else $error("ps2_receiver: key_valid high in two consecutive cycles");

endmodule

// File: verilog/tick_timer.sv
`timescale 1ns/1ns

module tick_timer import board_pkg::*; #(
    parameter int TICK_DIV = TICK_DIV_DEF
) (
    input  logic  CLOCK_50,
    input  logic  KEY0,
    output logic  tick,
    output word_t tick_count,
    output logic  heartbeat
);

    localparam int CNT_W = $clog2(TICK_DIV);

    logic [CNT_W-1:0] div_cnt;

    // Divider wraps at TICK_DIV - 1 and fires tick on the wrap
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (div_cnt == CNT_W'(TICK_DIV - 1)) begin
                div_cnt <= '0;
                tick    <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tick_count <= '0;
            heartbeat  <= 1'b0;
        end else if (tick) begin
            tick_count <= tick_count + 32'd1;
            heartbeat  <= ~heartbeat;
        end
    end

endmodule

// File: verilog/key_event_fifo.sv
`timescale 1ns/1ns

module key_event_fifo import kbd_pkg::*; #(
    // Must be a power of two
    parameter int KEY_DEPTH = 8
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       push,
    input  key_event_t push_event,
    input  logic       pop,
    output key_event_t head,
    output logic       empty
);

    localparam int AW = $clog2(KEY_DEPTH);

    key_event_t mem [KEY_DEPTH];

    // Extra pointer bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] count;
    logic        full;

    assign count = wr_ptr - rd_ptr;
    assign full  = (count == (AW + 1)'(KEY_DEPTH));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge CLOCK_50) begin
        if (push && !full) begin
            mem[wr_ptr[AW-1:0]] <= push_event;
        end
    end

    // Events arriving while full are lost
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) count <= (AW + 1)'(KEY_DEPTH))
        else $error("key_event_fifo: occupancy above KEY_DEPTH");

endmodule

// File: verilog/bus_fabric.sv
`timescale 1ns/1ns

module bus_fabric import board_pkg::*, kbd_pkg::*; #(
    parameter int MEM_WORDS = MEM_WORDS_DEF
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  addr_t      bus_address,
    input  word_t      bus_write_data,
    input  logic       bus_write_enable,
    input  logic       bus_read_enable,
    output word_t      bus_read_data,
    input  key_event_t key_head,
    input  logic       key_empty,
    output logic       key_pop,
    input  word_t      tick_count,
    output logic [7:0] uart_byte,
    output logic       uart_strobe
);

    localparam int RAM_BYTES = 4 * MEM_WORDS;
    localparam int IDX_W     = $clog2(MEM_WORDS);

    word_t mem [MEM_WORDS];

    addr_t            ram_offset;
    logic [IDX_W-1:0] ram_index;
    logic             ram_sel;
    logic             uart_sel;
    logic             key_sel;
    logic             timer_sel;
    word_t            read_mux;
    logic             uart_wr;
    logic             uart_wr_d;

    // Address decode
    assign ram_offset = bus_address - RAM_BASE;
    assign ram_index  = ram_offset[IDX_W+1:2];
    assign ram_sel    = (32'(ram_offset) < 32'(RAM_BYTES));
    assign uart_sel   = (bus_address == UART_ADDR);
    assign key_sel    = (bus_address == KEY_ADDR);
    assign timer_sel  = (bus_address == TIMER_ADDR);

    always_ff @(posedge CLOCK_50) begin
        if (bus_write_enable && ram_sel) begin
            mem[ram_index] <= bus_write_data;
        end
    end

    always_comb begin
        read_mux = '0;
        if (ram_sel) begin
            read_mux = mem[ram_index];
        end else if (key_sel && !key_empty) begin
            // Bit 31 marks a valid event
            read_mux = {1'b1, 22'b0, key_head};
        end else if (timer_sel) begin
            read_mux = tick_count;
        end
    end

    // Read data holds until the next read
    always_ff @(posedge CLOCK_50) begin
        if (bus_read_enable) begin
            bus_read_data <= read_mux;
        end
    end

    // Head leaves the queue in the cycle it is read
    assign key_pop = bus_read_enable && key_sel && !key_empty;

    // Console strobe only on the first cycle of a write
    assign uart_wr = bus_write_enable && uart_sel;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_wr_d   <= 1'b0;
            uart_strobe <= 1'b0;
        end else begin
            uart_wr_d   <= uart_wr;
            uart_strobe <= uart_wr && !uart_wr_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (uart_wr && !uart_wr_d) begin
            uart_byte <= bus_write_data[7:0];
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_write_enable && bus_read_enable))
        else $error("bus_fabric: read and write enable high together");

endmodule

// File: verilog/irq_ctrl.sv
`timescale 1ns/1ns

module irq_ctrl import board_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     key_make,
    input  logic     tick,
    input  logic     irq_ack,
    output irq_vec_t irq_vector
);

    logic key_pending;
    logic timer_pending;
    logic key_next;
    logic timer_next;

    // Ack clears only the shown source unless that source fires again
    assign key_next   = key_make ||
                        (key_pending && !(irq_ack && irq_vector == IRQ_KEY));
    assign timer_next = tick ||
                        (timer_pending && !(irq_ack && irq_vector == IRQ_TIMER));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_pending   <= 1'b0;
            timer_pending <= 1'b0;
            irq_vector    <= IRQ_NONE;
        end else begin
            key_pending   <= key_next;
            timer_pending <= timer_next;
            // Keyboard before timer
            if (key_next) begin
                irq_vector <= IRQ_KEY;
            end else if (timer_next) begin
                irq_vector <= IRQ_TIMER;
            end else begin
                irq_vector <= IRQ_NONE;
            end
        end
    end

endmodule

// File: verilog/board_io_top.sv
`timescale 1ns/1ns

module board_io_top import board_pkg::*, kbd_pkg::*; #(
    parameter int MEM_WORDS = MEM_WORDS_DEF,
    parameter int TICK_DIV  = TICK_DIV_DEF,
    parameter int KEY_DEPTH = KEY_DEPTH_DEF
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  addr_t      bus_address,
    input  word_t      bus_write_data,
    input  logic       bus_write_enable,
    input  logic       bus_read_enable,
    output word_t      bus_read_data,
    output irq_vec_t   irq_vector,
    input  logic       irq_ack,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] uart_byte,
    output logic       uart_strobe,
    output logic       heartbeat
);

    key_event_t key_event;
    logic       key_valid;
    logic       key_make;
    key_event_t key_head;
    logic       key_empty;
    logic       key_pop;
    logic       tick;
    word_t      tick_count;

    ps2_receiver ps2_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .key_event(key_event),
        .key_valid(key_valid),
        .key_make (key_make)
    );

    key_event_fifo #(.KEY_DEPTH(KEY_DEPTH)) key_fifo_i (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .push      (key_valid),
        .push_event(key_event),
        .pop       (key_pop),
        .head      (key_head),
        .empty     (key_empty)
    );

    tick_timer #(.TICK_DIV(TICK_DIV)) timer_i (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .tick      (tick),
        .tick_count(tick_count),
        .heartbeat (heartbeat)
    );

    irq_ctrl irq_i (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .key_make  (key_make),
        .tick      (tick),
        .irq_ack   (irq_ack),
        .irq_vector(irq_vector)
    );

    bus_fabric #(.MEM_WORDS(MEM_WORDS)) fabric_i (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_address     (bus_address),
        .bus_write_data  (bus_write_data),
        .bus_write_enable(bus_write_enable),
        .bus_read_enable (bus_read_enable),
        .bus_read_data   (bus_read_data),
        .key_head        (key_head),
        .key_empty       (key_empty),
        .key_pop         (key_pop),
        .tick_count      (tick_count),
        .uart_byte       (uart_byte),
        .uart_strobe     (uart_strobe)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);

    // 50 MHz board clock
    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // Reset held low for five cycles
    initial begin
        KEY0 = 1'b0;
        repeat (5) @(posedge CLOCK_50);
        #2 KEY0 = 1'b1;
    end

endmodule

// File: tb/tb_board.sv
`timescale 1ns/1ns

module tb_board import board_pkg::*, kbd_pkg::*; ();

    localparam int MEM_WORDS  = 2048;
    localparam int TICK_DIV   = 200;
    localparam int PS2_HALF   = 10;
    localparam int CLK_PERIOD = 20;
    // Eleven bits with two half periods each, plus idle after the frame
    localparam int FRAME_CYCLES = 22 * PS2_HALF + PS2_HALF;
    localparam int FRAME_COUNT  = 10;
    localparam int RUN_CYCLES   = FRAME_COUNT * FRAME_CYCLES + 12 * TICK_DIV + 1500;

    logic       CLOCK_50;
    logic       KEY0;
    addr_t      bus_address;
    word_t      bus_write_data;
    logic       bus_write_enable;
    logic       bus_read_enable;
    word_t      bus_read_data;
    irq_vec_t   irq_vector;
    logic       irq_ack;
    logic       ps2_clk;
    logic       ps2_dat;
    logic [7:0] uart_byte;
    logic       uart_strobe;
    logic       heartbeat;

    int    errors = 0;
    int    seed   = 72808;
    word_t ram_model [MEM_WORDS];
    addr_t ram_addrs [32];

    tb_clock clock_i (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0)
    );

    board_io_top #(
        .MEM_WORDS(MEM_WORDS),
        .TICK_DIV (TICK_DIV)
    ) dut_i (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_address     (bus_address),
        .bus_write_data  (bus_write_data),
        .bus_write_enable(bus_write_enable),
        .bus_read_enable (bus_read_enable),
        .bus_read_data   (bus_read_data),
        .irq_vector      (irq_vector),
        .irq_ack         (irq_ack),
        .ps2_clk         (ps2_clk),
        .ps2_dat         (ps2_dat),
        .uart_byte       (uart_byte),
        .uart_strobe     (uart_strobe),
        .heartbeat       (heartbeat)
    );

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_event(input key_event_t got, input key_event_t exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s got released=%0b code=%h expected released=%0b code=%h",
                     $time, what, got.released, got.code, exp.released, exp.code);
        end
    endtask

    task automatic check_vector(input irq_vec_t got, input irq_vec_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s got vector %0d expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic key_event_t make_event(input logic released, input scan_code_t code);
        make_event.released = released;
        make_event.code     = code;
    endfunction

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLOCK_50);
        #2;
    endtask

    task automatic bus_write(input addr_t addr, input word_t data);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        next_cycle();
        bus_write_enable = 1'b0;
    endtask

    // Data is registered at the sampling edge
    task automatic bus_read(input addr_t addr, output word_t data);
        bus_address     = addr;
        bus_read_enable = 1'b1;
        next_cycle();
        bus_read_enable = 1'b0;
        data            = bus_read_data;
    endtask

    task automatic read_key(input logic present, input key_event_t exp, input string what);
        word_t rd;
        bus_read(KEY_ADDR, rd);
        if (present) begin
            check_word(rd & 32'hFFFF_FE00, 32'h8000_0000, {what, " valid flag"});
            check_event(key_event_t'(rd[8:0]), exp, what);
        end else begin
            check_word(rd, '0, what);
        end
    endtask

    // Start, eight data bits LSB first, odd parity, stop
    task automatic send_frame(input scan_code_t code, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        parity = ~^code ^ bad_parity;
        frame  = {1'b1, parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = frame[i];
            repeat (PS2_HALF) next_cycle();
            ps2_clk = 1'b0;
            repeat (PS2_HALF) next_cycle();
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        repeat (PS2_HALF) next_cycle();
    endtask

    task automatic pulse_ack();
        irq_ack = 1'b1;
        next_cycle();
        irq_ack = 1'b0;
    endtask

    // Heartbeat and vector both change one cycle after the tick
    task automatic wait_tick();
        logic start;
        int   n;
        start = heartbeat;
        n     = 0;
        while (heartbeat === start && n < 2 * TICK_DIV) begin
            next_cycle();
            n++;
        end
        if (heartbeat === start) begin
            errors++;
            $display("No timer tick seen within %0d cycles at %0t ns", 2 * TICK_DIV, $time);
        end
    endtask

    task automatic ram_readback();
        word_t data;
        word_t rd;
        for (int i = 0; i < 32; i++) begin
            ram_addrs[i] = addr_t'($random(seed)) & addr_t'((MEM_WORDS * 4 - 1) & ~3);
            data = $random(seed);
            bus_write(ram_addrs[i], data);
            ram_model[ram_addrs[i] >> 2] = data;
        end
        // Rewrite the first address so the newer word must come back
        data = ~ram_model[ram_addrs[0] >> 2];
        bus_write(ram_addrs[0], data);
        ram_model[ram_addrs[0] >> 2] = data;
        for (int i = 0; i < 32; i++) begin
            bus_read(ram_addrs[i], rd);
            check_word(rd, ram_model[ram_addrs[i] >> 2], "ram read");
        end
    endtask

    task automatic console_strobe(input word_t data, input int hold);
        int strobes;
        strobes          = 0;
        bus_address      = UART_ADDR;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        for (int n = 1; n <= hold + 3; n++) begin
            next_cycle();
            if (uart_strobe) begin
                strobes++;
                check_word(word_t'(uart_byte), word_t'(data[7:0]), "console byte");
            end
            if (n == hold) begin
                bus_write_enable = 1'b0;
            end
        end
        check_word(word_t'(strobes), 32'd1, "console strobe count");
    endtask

    task automatic keyboard_events();
        send_frame(8'h1C, 1'b0);
        send_frame(BREAK_CODE, 1'b0);
        send_frame(8'h1C, 1'b0);
        read_key(1'b1, make_event(1'b0, 8'h1C), "key press");
        read_key(1'b1, make_event(1'b1, 8'h1C), "key release");
        read_key(1'b0, '0, "key queue empty");
    endtask

    task automatic bad_frame_rejection();
        send_frame(8'h1C, 1'b1);
        read_key(1'b0, '0, "bad parity frame");
        send_frame(BREAK_CODE, 1'b0);
        send_frame(8'h55, 1'b1);
        send_frame(8'h32, 1'b0);
        read_key(1'b1, make_event(1'b0, 8'h32), "press after broken release");
        read_key(1'b0, '0, "key queue empty after bad frames");
    endtask

    task automatic interrupt_priority();
        wait_tick();
        repeat (3) begin
            if (irq_vector != IRQ_NONE) begin
                pulse_ack();
            end
        end
        check_vector(irq_vector, IRQ_NONE, "all sources cleared");
        wait_tick();
        check_vector(irq_vector, IRQ_TIMER, "timer tick");
        pulse_ack();
        check_vector(irq_vector, IRQ_NONE, "timer ack");
        // A tick lands inside the frame, so both end up pending
        send_frame(8'h1C, 1'b0);
        check_vector(irq_vector, IRQ_KEY, "make code over pending tick");
        pulse_ack();
        check_vector(irq_vector, IRQ_TIMER, "key ack");
        pulse_ack();
        check_vector(irq_vector, IRQ_NONE, "second ack");
        read_key(1'b1, make_event(1'b0, 8'h1C), "interrupt key press");
        send_frame(BREAK_CODE, 1'b0);
        send_frame(8'h1C, 1'b0);
        check_vector(irq_vector, IRQ_TIMER, "release shows only the timer");
        wait_tick();
        pulse_ack();
        check_vector(irq_vector, IRQ_NONE, "ack after release");
        read_key(1'b1, make_event(1'b1, 8'h1C), "interrupt key release");
    endtask

    task automatic timer_count();
        word_t first;
        word_t second;
        logic  hb_last;
        int    toggles;
        toggles = 0;
        bus_read(TIMER_ADDR, first);
        hb_last = heartbeat;
        // Second read sampled exactly 3 * TICK_DIV edges later
        for (int n = 1; n < 3 * TICK_DIV; n++) begin
            next_cycle();
            if (heartbeat !== hb_last) begin
                toggles++;
            end
            hb_last = heartbeat;
        end
        bus_read(TIMER_ADDR, second);
        if (heartbeat !== hb_last) begin
            toggles++;
        end
        check_word(second - first, 32'd3, "tick count difference");
        check_word(word_t'(toggles % 2), 32'd1, "heartbeat toggle parity");
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", RUN_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        irq_ack          = 1'b0;
        ps2_clk          = 1'b1;
        ps2_dat          = 1'b1;
        @(posedge KEY0);
        next_cycle();
        check_vector(irq_vector, IRQ_NONE, "vector after reset");
        check_word(word_t'({heartbeat, uart_strobe}), '0, "outputs after reset");
        ram_readback();
        console_strobe($random(seed), 1);
        console_strobe($random(seed), 3);
        keyboard_events();
        bad_frame_rejection();
        interrupt_priority();
        timer_count();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/board_pkg.sv
verilog/kbd_pkg.sv
verilog/ps2_receiver.sv
verilog/tick_timer.sv
verilog/key_event_fifo.sv
verilog/bus_fabric.sv
verilog/irq_ctrl.sv
verilog/board_io_top.sv
tb/tb_clock.sv
tb/tb_board.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the board I/O testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board \
    -f src.f \
    -o tb_board_sim

./obj_dir/tb_board_sim 2>&1 | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished, log in $LOG"
exit 0
